/* design/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;

    // ALU operations known to execute
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6  // LUI passes the immediate through
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic alu_src_imm;  // Second operand is the immediate
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic is_branch;
        logic branch_ne;    // BNE when set, BEQ otherwise
    } ctrl_t;

    // Fetch to decode
    typedef struct packed {
        logic valid;
        word_t pc;
        word_t instr;
    } if_de_t;

    // Decode to execute
    typedef struct packed {
        logic valid;
        word_t pc;
        word_t imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t value1;
        word_t value2;
        ctrl_t ctrl;
    } de_ex_t;

    // Execute to memory
    typedef struct packed {
        logic valid;
        word_t result;      // ALU result, also the data address
        word_t store_data;
        reg_addr_t rd;
        ctrl_t ctrl;
    } ex_mem_t;

    // Memory to writeback, drives the register write port
    typedef struct packed {
        logic valid;
        logic reg_write;
        reg_addr_t rd;
        word_t value;
    } mem_wb_t;

    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;

endpackage

/* design/register_bank.sv */
`timescale 1ns/1ps

module register_bank (
    input logic clk,
    input logic reset,
    input logic write_enable,
    input cpu_pkg::reg_addr_t write_address,
    input cpu_pkg::word_t write_value,
    input cpu_pkg::reg_addr_t read_address1,
    input cpu_pkg::reg_addr_t read_address2,
    output cpu_pkg::word_t value1,
    output cpu_pkg::word_t value2
);
    cpu_pkg::word_t regs [32];

    // Write-through so decode sees the value written this cycle
    function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t address);
        if (address == '0)
            return '0;
        if (write_enable && write_address == address)
            return write_value;
        return regs[address];
    endfunction

    always_comb begin
        value1 = read_port(read_address1);
        value2 = read_port(read_address2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && write_address != '0)
            regs[write_address] <= write_value;
    end
endmodule

/* design/fetch.sv */
`timescale 1ns/1ps

module fetch #(
    parameter int ROM_ADDR_WIDTH = 8
) (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic hold,
    input logic branch_taken,
    input cpu_pkg::word_t branch_target,
    input cpu_pkg::word_t rom_data,
    output logic [ROM_ADDR_WIDTH-1:0] rom_address,
    output cpu_pkg::if_de_t if_de
);
    cpu_pkg::word_t pc;
    cpu_pkg::word_t req_pc;  // Address of the word now coming back from the ROM
    logic req_valid;         // Cleared by a redirect
    logic frozen;

    assign frozen = hold || !enable;

    // While frozen the ROM reads the in-flight address again,
    // so rom_data stays paired with req_pc
    assign rom_address = frozen ? req_pc[ROM_ADDR_WIDTH+1:2] : pc[ROM_ADDR_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            req_pc <= '0;
            req_valid <= 1'b0;
            if_de <= '0;
        end else if (enable) begin
            if (branch_taken) begin
                pc <= branch_target;
                req_valid <= 1'b0;   // Drop the word in flight
                if_de.valid <= 1'b0;
            end else if (!hold) begin
                pc <= pc + 32'd4;
                req_pc <= pc;
                req_valid <= 1'b1;
                if_de <= '{valid: req_valid, pc: req_pc, instr: rom_data};
            end
        end
    end
endmodule

/* design/decode.sv */
`timescale 1ns/1ps

module decode (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic branch_taken,
    input cpu_pkg::if_de_t if_de,
    input cpu_pkg::word_t value1,
    input cpu_pkg::word_t value2,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output logic hold,
    output cpu_pkg::de_ex_t de_ex
);
    cpu_pkg::opcode_t opcode;
    logic [2:0] funct3;
    logic funct7_5;          // Picks SUB over ADD
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t imm;
    cpu_pkg::ctrl_t ctrl;

    assign opcode = if_de.instr[6:0];
    assign rd = if_de.instr[11:7];
    assign funct3 = if_de.instr[14:12];
    assign rs1 = if_de.instr[19:15];
    assign rs2 = if_de.instr[24:20];
    assign funct7_5 = if_de.instr[30];

    always_comb begin
        ctrl = '0;
        imm = {{20{if_de.instr[31]}}, if_de.instr[31:20]};  // I-type
        case (opcode)
            cpu_pkg::OP_R: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = funct7_5 ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b010: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    3'b100: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    3'b110: ctrl.alu_op = cpu_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = cpu_pkg::ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_I: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    3'b100: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    3'b110: ctrl.alu_op = cpu_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = cpu_pkg::ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read = (funct3 == 3'b010);  // LW only
                ctrl.reg_write = (funct3 == 3'b010);
            end
            cpu_pkg::OP_STORE: begin
                imm = {{20{if_de.instr[31]}}, if_de.instr[31:25], if_de.instr[11:7]};
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write = (funct3 == 3'b010);  // SW only
            end
            cpu_pkg::OP_BRANCH: begin
                imm = {{20{if_de.instr[31]}}, if_de.instr[7], if_de.instr[30:25],
                       if_de.instr[11:8], 1'b0};
                ctrl.is_branch = (funct3[2:1] == 2'b00);  // BEQ and BNE
                ctrl.branch_ne = funct3[0];
            end
            cpu_pkg::OP_LUI: begin
                imm = {if_de.instr[31:12], 12'b0};
                ctrl.alu_op = cpu_pkg::ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ;  // No-op
        endcase
        if (rd == '0)
            ctrl.reg_write = 1'b0;  // x0 never written nor forwarded
    end

    // Load in execute feeding the instruction here
    assign hold = if_de.valid && de_ex.valid && de_ex.ctrl.mem_read && de_ex.ctrl.reg_write
                  && (de_ex.rd == rs1 || de_ex.rd == rs2);

    always_ff @(posedge clk) begin
        if (reset)
            de_ex <= '0;
        else if (enable) begin
            if (branch_taken || hold)
                de_ex <= '0;  // Bubble
            else
                de_ex <= '{valid: if_de.valid, pc: if_de.pc, imm: imm, rs1: rs1, rs2: rs2,
                           rd: rd, value1: value1, value2: value2, ctrl: ctrl};
        end
    end
endmodule

/* design/execute.sv */
`timescale 1ns/1ps

module execute (
    input logic clk,
    input logic reset,
    input logic enable,
    input cpu_pkg::de_ex_t de_ex,
    input cpu_pkg::mem_wb_t mem_wb,
    output cpu_pkg::ex_mem_t ex_mem,
    output logic branch_taken,
    output cpu_pkg::word_t branch_target
);
    cpu_pkg::word_t op1, op2;  // After forwarding
    cpu_pkg::word_t operand_b;
    cpu_pkg::word_t result;
    logic equal;

    // The younger producer wins, so ex_mem is checked first
    function automatic cpu_pkg::word_t forward(cpu_pkg::reg_addr_t rs,
                                               cpu_pkg::word_t bank_value);
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd == rs)
            return ex_mem.result;
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == rs)
            return mem_wb.value;
        return bank_value;
    endfunction

    always_comb begin
        op1 = forward(de_ex.rs1, de_ex.value1);
        op2 = forward(de_ex.rs2, de_ex.value2);
    end

    assign operand_b = de_ex.ctrl.alu_src_imm ? de_ex.imm : op2;

    always_comb begin
        case (de_ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: result = op1 + operand_b;
            cpu_pkg::ALU_SUB: result = op1 - operand_b;
            cpu_pkg::ALU_AND: result = op1 & operand_b;
            cpu_pkg::ALU_OR: result = op1 | operand_b;
            cpu_pkg::ALU_XOR: result = op1 ^ operand_b;
            cpu_pkg::ALU_SLT: result = {31'b0, $signed(op1) < $signed(operand_b)};
            cpu_pkg::ALU_PASS_B: result = operand_b;
            default: result = '0;
        endcase
    end

    // Branches compare the two registers, never the immediate
    assign equal = (op1 == op2);
    assign branch_taken = de_ex.valid && de_ex.ctrl.is_branch && (equal ^ de_ex.ctrl.branch_ne);
    assign branch_target = de_ex.pc + de_ex.imm;

    always_ff @(posedge clk) begin
        if (reset)
            ex_mem <= '0;
        else if (enable) begin
            ex_mem.valid <= de_ex.valid;
            ex_mem.result <= result;
            ex_mem.store_data <= op2;
            ex_mem.rd <= de_ex.rd;
            ex_mem.ctrl <= de_ex.ctrl;  // Branch ctrl has no write bits set
        end
    end
endmodule

/* design/memory.sv */
`timescale 1ns/1ps

module memory #(
    parameter int RAM_WORDS = 64,
    parameter cpu_pkg::word_t PORT_ADDR = 32'h80
) (
    input logic clk,
    input logic reset,
    input logic enable,
    input cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::mem_wb_t mem_wb,
    output cpu_pkg::word_t port_data,
    output logic port_write
);
    localparam int RAM_ADDR_WIDTH = $clog2(RAM_WORDS);

    cpu_pkg::word_t ram [RAM_WORDS];
    logic [RAM_ADDR_WIDTH-1:0] ram_index;  // Word address
    logic is_port;
    logic do_store;
    cpu_pkg::word_t load_data;

    assign ram_index = ex_mem.result[RAM_ADDR_WIDTH+1:2];
    assign is_port = (ex_mem.result == PORT_ADDR);
    assign do_store = enable && ex_mem.valid && ex_mem.ctrl.mem_write;

    // Port address reads back the last value written
    assign load_data = is_port ? port_data : ram[ram_index];

    always_ff @(posedge clk) begin
        if (do_store && !is_port)
            ram[ram_index] <= ex_mem.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
            port_data <= '0;
            port_write <= 1'b0;
        end else begin
            port_write <= do_store && is_port;  // One cycle strobe
            if (do_store && is_port)
                port_data <= ex_mem.store_data;
            if (enable) begin
                mem_wb.valid <= ex_mem.valid;
                mem_wb.reg_write <= ex_mem.ctrl.reg_write;
                mem_wb.rd <= ex_mem.rd;
                mem_wb.value <= ex_mem.ctrl.mem_read ? load_data : ex_mem.result;
            end
        end
    end
endmodule

/* design/cpu.sv */
`timescale 1ns/1ps

module cpu #(
    parameter int ROM_ADDR_WIDTH = 8,
    parameter int RAM_WORDS = 64,
    parameter cpu_pkg::word_t PORT_ADDR = 32'h80
) (
    input logic clock,
    input logic reset,
    input logic enable,
    input cpu_pkg::word_t rom_data,
    output logic [ROM_ADDR_WIDTH-1:0] rom_address,
    output cpu_pkg::word_t port_data,
    output logic port_write
);
    // Stage registers
    cpu_pkg::if_de_t if_de;
    cpu_pkg::de_ex_t de_ex;
    cpu_pkg::ex_mem_t ex_mem;
    cpu_pkg::mem_wb_t mem_wb;

    // Register bank
    cpu_pkg::reg_addr_t rs1, rs2;
    cpu_pkg::word_t value1, value2;
    logic rb_write_enable;

    logic hold;                      // Load-use bubble
    logic branch_taken;
    cpu_pkg::word_t branch_target;

    assign rb_write_enable = mem_wb.valid && mem_wb.reg_write;

    fetch #(
        .ROM_ADDR_WIDTH(ROM_ADDR_WIDTH)
    ) i_fetch (
        .clk(clock),
        .reset(reset),
        .enable(enable),
        .hold(hold),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .if_de(if_de)
    );

    decode i_decode (
        .clk(clock),
        .reset(reset),
        .enable(enable),
        .branch_taken(branch_taken),
        .if_de(if_de),
        .value1(value1),
        .value2(value2),
        .rs1(rs1),
        .rs2(rs2),
        .hold(hold),
        .de_ex(de_ex)
    );

    register_bank i_register_bank (
        .clk(clock),
        .reset(reset),
        .write_enable(rb_write_enable),
        .write_address(mem_wb.rd),
        .write_value(mem_wb.value),
        .read_address1(rs1),
        .read_address2(rs2),
        .value1(value1),
        .value2(value2)
    );

    execute i_execute (
        .clk(clock),
        .reset(reset),
        .enable(enable),
        .de_ex(de_ex),
        .mem_wb(mem_wb),
        .ex_mem(ex_mem),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    memory #(
        .RAM_WORDS(RAM_WORDS),
        .PORT_ADDR(PORT_ADDR)
    ) i_memory (
        .clk(clock),
        .reset(reset),
        .enable(enable),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .port_data(port_data),
        .port_write(port_write)
    );
endmodule

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    localparam int STIM_WORDS = 1024;
    localparam int QUIET_CYCLES = 50;  // No extra write allowed this long after the last one
    localparam int RESET_CYCLES = 4;
    localparam cpu_pkg::word_t SELF_BRANCH = 32'h00000063;  // beq x0, x0, 0

    logic clock;
    logic reset = 1'b1;
    logic enable = 1'b1;
    cpu_pkg::word_t rom_data = '0;
    logic [7:0] rom_address;
    cpu_pkg::word_t port_data;
    logic port_write;

    cpu_pkg::word_t stim [STIM_WORDS];
    cpu_pkg::word_t program_words [256];
    int program_length = 0;
    logic random_stalls = 1'b0;
    logic [31:0] rng_state = 32'hc87bfcfb;
    int watchdog_cycles = 0;
    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    cpu i_dut (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .port_data(port_data),
        .port_write(port_write)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Synchronous ROM that keeps the core spinning in place past the end
    always @(posedge clock) begin
        if (int'(rom_address) < program_length)
            rom_data <= program_words[rom_address];
        else
            rom_data <= SELF_BRANCH;
        if (random_stalls) begin
            rng_state <= xorshift(rng_state);
            enable <= (rng_state[1:0] != 2'b00);  // Low about one cycle in four
        end else
            enable <= 1'b1;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout after %0d cycles, a test never got all its port writes",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic run_test(input int index, input int base);
        int expect_count;
        int reset_after;
        int reset_left;
        int seen;
        int quiet;
        int errors_before;
        int i;
        cpu_pkg::word_t expected [$];
        @(negedge clock);  // Program swap away from the ROM edge
        program_length = int'(stim[base]);
        expect_count = int'(stim[base + 1]);
        reset_after = int'(stim[base + 2]);
        random_stalls = stim[base + 3][0];
        for (i = 0; i < program_length; i++)
            program_words[i] = stim[base + 4 + i];
        for (i = 0; i < expect_count; i++)
            expected.push_back(stim[base + 4 + program_length + i]);
        errors_before = error_count;
        seen = 0;
        quiet = 0;
        @(posedge clock);
        reset <= 1'b1;
        reset_left = RESET_CYCLES;
        while (quiet < QUIET_CYCLES) begin
            @(posedge clock);
            if (reset_left > 0) begin
                reset_left--;
                if (reset_left == 0)
                    reset <= 1'b0;
            end
            if (port_write) begin
                if (seen >= expect_count) begin
                    $display("Unexpected extra port write of %08h at %0d ns in test %0d",
                             port_data, $time, index);
                    error_count++;
                end else if (port_data !== expected[seen]) begin
                    $display("error at %0d ns: port_data expected %08h, actual %08h",
                             $time, expected[seen], port_data);
                    error_count++;
                end
                seen++;
                quiet = 0;
                if (seen == reset_after) begin  // Restart the program midway
                    reset <= 1'b1;
                    reset_left = RESET_CYCLES;
                end
            end else if (seen >= expect_count)
                quiet++;
        end
        if (error_count == errors_before && seen == expect_count) begin
            tests_passed++;
            $display("test %0d passed, %0d port writes", index, seen);
        end else begin
            tests_failed++;
            $display("test %0d FAILED, %0d port writes for %0d expected", index, seen,
                     expect_count);
        end
    endtask

    initial begin
        int base;
        int index;
        int total_cycles;
        $readmemh("test/cpu_stim.txt", stim);
        base = 0;
        total_cycles = 0;
        while (stim[base] != '0) begin
            total_cycles += 40 * int'(stim[base]) + 200;
            base += 4 + int'(stim[base]) + int'(stim[base + 1]);
        end
        watchdog_cycles = total_cycles;
        base = 0;
        index = 1;
        while (stim[base] != '0) begin
            run_test(index, base);
            base += 4 + int'(stim[base]) + int'(stim[base + 1]);
            index++;
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors", index - 1,
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && index > 1)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end
endmodule

/* test/cpu_stim.txt */
// Header: program words, expected port writes, writes before a mid-run reset (0 none), stall flag
// Then the program words and the expected port values in order; a zero length ends the file
// Test 1 forwarding through both paths, LUI, SLT and logic ops
00000015 00000006 00000000 00000000
00500093 // addi x1, x0, 5
00708113 // addi x2, x1, 7
002081B3 // add x3, x1, x2
08302023 // sw x3, 0x80(x0)
40118233 // sub x4, x3, x1
123452B7 // lui x5, 0x12345
0042C333 // xor x6, x5, x4
08402023 // sw x4, 0x80(x0)
08602023 // sw x6, 0x80(x0)
0020A3B3 // slt x7, x1, x2
FFD00093 // addi x1, x0, -3
0070A133 // slt x2, x1, x7
00710133 // add x2, x2, x7
08202023 // sw x2, 0x80(x0)
0FF37193 // andi x3, x6, 0xff
7001E193 // ori x3, x3, 0x700
FFF1C193 // xori x3, x3, -1
08302023 // sw x3, 0x80(x0)
0061F233 // and x4, x3, x6
00126233 // or x4, x4, x1
08402023 // sw x4, 0x80(x0)
00000011 0000000C 1234500C 00000002 FFFFF8F3 FFFFFFFD
// Test 2 store then load, load-use holds
0000000C 00000003 00000000 00000000
05500093 // addi x1, x0, 0x55
00102423 // sw x1, 8(x0)
00400113 // addi x2, x0, 4
00412183 // lw x3, 4(x2)
00118213 // addi x4, x3, 1
08402023 // sw x4, 0x80(x0)
00802283 // lw x5, 8(x0)
08502023 // sw x5, 0x80(x0)
00402623 // sw x4, 12(x0)
00C02303 // lw x6, 12(x0)
006303B3 // add x7, x6, x6
08702023 // sw x7, 0x80(x0)
00000056 00000055 000000AC
// Test 3 BEQ and BNE, loop to five, flushed stores
00000010 00000008 00000000 00000000
00500113 // addi x2, x0, 5
00108093 // addi x1, x1, 1
08102023 // sw x1, 0x80(x0)
FE209CE3 // bne x1, x2, -8
00208663 // beq x1, x2, +12
08002023 // sw x0, 0x80(x0) skipped
08202023 // sw x2, 0x80(x0) skipped
00900193 // addi x3, x0, 9
00118463 // beq x3, x1, +8 not taken
08302023 // sw x3, 0x80(x0)
00319463 // bne x3, x3, +8 not taken
00118193 // addi x3, x3, 1
08302023 // sw x3, 0x80(x0)
00019463 // bne x3, x0, +8
08002023 // sw x0, 0x80(x0) skipped
08102023 // sw x1, 0x80(x0)
00000001 00000002 00000003 00000004 00000005 00000009 0000000A 00000005
// Test 4 load, branch loop under random enable stalls
0000000B 00000004 00000000 00000001
00300093 // addi x1, x0, 3
00102823 // sw x1, 16(x0)
01002103 // lw x2, 16(x0)
00110133 // add x2, x2, x1
00202823 // sw x2, 16(x0)
08202023 // sw x2, 0x80(x0)
00118193 // addi x3, x3, 1
FE1196E3 // bne x3, x1, -20
ABCDE237 // lui x4, 0xabcde
12326213 // ori x4, x4, 0x123
08402023 // sw x4, 0x80(x0)
00000006 00000009 0000000C ABCDE123
// Test 5 x0 stays zero, reset after the third write restarts the program
0000000B 00000007 00000003 00000000
00700013 // addi x0, x0, 7
02100093 // addi x1, x0, 0x21
08102023 // sw x1, 0x80(x0)
08002023 // sw x0, 0x80(x0)
00518193 // addi x3, x3, 5
08302023 // sw x3, 0x80(x0)
00100213 // addi x4, x0, 1
00120213 // addi x4, x4, 1
00120213 // addi x4, x4, 1
00120213 // addi x4, x4, 1
08402023 // sw x4, 0x80(x0)
00000021 00000000 00000005 00000021 00000000 00000005 00000004
00000000

/* vlog.f */
design/cpu_pkg.sv
design/register_bank.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/cpu.sv
test/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu -f vlog.f -o tb_cpu || exit 1

./obj_dir/tb_cpu | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
